// ==== source/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte address and data word
`define DCACHE_ADDR_BITS 32
`define DCACHE_WORD_BITS 32

// 16-byte lines
`define DCACHE_OFFSET_BITS 4

// 8 sets, small on purpose so evictions come early
`define DCACHE_INDEX_BITS 3
`define DCACHE_NUM_SETS (1 << `DCACHE_INDEX_BITS)

// one burst beat per word
`define DCACHE_WORDS_PER_LINE 4

// single LRU bit per set assumes two ways
`define DCACHE_NUM_WAYS 2

`endif

// ==== source/dcache_pkg.sv ====
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DCACHE_WORD_BITS-1:0] word_t;
    typedef logic [`DCACHE_WORD_BITS/8-1:0] strb_t;
    typedef logic [`DCACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [`DCACHE_ADDR_BITS-`DCACHE_INDEX_BITS-`DCACHE_OFFSET_BITS-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;
    typedef logic [$clog2(`DCACHE_WORDS_PER_LINE)-1:0] word_sel_t;
    typedef logic [$clog2(`DCACHE_NUM_WAYS)-1:0] way_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } meta_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB_ADDR,
        S_WB_DATA,
        S_WB_RESP,
        S_RF_ADDR,
        S_RF_DATA,
        S_RESPOND
    } fsm_state_t;

    // address split: tag | index | word | byte
    function automatic tag_t addr_tag(addr_t a);
        return a[`DCACHE_ADDR_BITS-1 -: $bits(tag_t)];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
    endfunction

    function automatic word_sel_t addr_word(addr_t a);
        return a[`DCACHE_OFFSET_BITS-1 -: $bits(word_sel_t)];
    endfunction

endpackage

// ==== source/mem_bus_pkg.sv ====
`include "dcache_config.svh"

package mem_bus_pkg;

    // always line aligned, burst starts at word 0
    typedef logic [`DCACHE_ADDR_BITS-1:0] mem_addr_t;

    typedef struct packed {
        logic [`DCACHE_WORD_BITS-1:0] data;
        logic                         last;
    } mem_rbeat_t;

    // full-word beats only, so no strobe
    typedef struct packed {
        logic [`DCACHE_WORD_BITS-1:0] data;
        logic                         last;
    } mem_wbeat_t;

endpackage

// ==== source/sync_ram.sv ====
module sync_ram #(
    parameter type data_t = logic [31:0],
    parameter int  DEPTH  = 8
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  data_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output data_t                    rdata
);

    data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // old contents on collision
    end

endmodule

// ==== source/beat_counter.sv ====
`include "dcache_config.svh"

module beat_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  step,
    output dcache_pkg::word_sel_t count,
    output logic                  last
);

    import dcache_pkg::*;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;  // wraps after the final word
        end
    end

    assign last = (count == word_sel_t'(`DCACHE_WORDS_PER_LINE - 1));

endmodule

// ==== source/dcache_meta.sv ====
`include "dcache_config.svh"

module dcache_meta (
    input  logic                                       clk,
    input  logic                                       rst,
    input  dcache_pkg::index_t                         index,
    input  dcache_pkg::tag_t                           lookup_tag,
    input  dcache_pkg::tag_t [`DCACHE_NUM_WAYS-1:0]    way_tags,
    input  logic                                       touch,
    input  dcache_pkg::way_t                           touch_way,
    input  logic                                       set_dirty,
    input  logic                                       fill,
    input  dcache_pkg::way_t                           fill_way,
    output logic                                       hit,
    output dcache_pkg::way_t                           hit_way,
    output dcache_pkg::way_t                           victim_way,
    output logic                                       victim_dirty
);

    import dcache_pkg::*;

    meta_t [`DCACHE_NUM_WAYS-1:0] line_meta [`DCACHE_NUM_SETS];
    logic                         lru [`DCACHE_NUM_SETS];  // names the next victim
    index_t                       index_q;
    logic [`DCACHE_NUM_WAYS-1:0]  way_hit;

    // follows the RAM read address, so it lines up with way_tags
    always_ff @(posedge clk) begin
        index_q <= index;
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
            way_hit[w] = line_meta[index_q][w].valid && (way_tags[w] == lookup_tag);
        end
    end

    assign hit          = |way_hit;
    assign hit_way      = way_t'(way_hit[1]);
    assign victim_way   = way_t'(lru[index_q]);
    assign victim_dirty = line_meta[index_q][victim_way].valid &&
                          line_meta[index_q][victim_way].dirty;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DCACHE_NUM_SETS; s++) begin
                line_meta[s] <= '0;
                lru[s]       <= 1'b0;
            end
        end else begin
            if (fill) begin
                line_meta[index_q][fill_way].valid <= 1'b1;
                line_meta[index_q][fill_way].dirty <= 1'b0;
            end
            // after fill, so a store miss leaves the new line dirty
            if (touch) begin
                lru[index_q] <= ~touch_way;
                if (set_dirty) begin
                    line_meta[index_q][touch_way].dirty <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/dcache_fsm.sv ====
`include "dcache_config.svh"

module dcache_fsm (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    req_valid,
    output logic                                    req_ready,
    input  dcache_pkg::cpu_req_t                    req,
    output logic                                    resp_valid,
    output dcache_pkg::cpu_resp_t                   resp,
    input  dcache_pkg::word_t [`DCACHE_NUM_WAYS-1:0] rdata_way,
    input  dcache_pkg::tag_t [`DCACHE_NUM_WAYS-1:0]  tag_way,
    input  logic                                    hit,
    input  dcache_pkg::way_t                        hit_way,
    input  dcache_pkg::way_t                        victim_way,
    input  logic                                    victim_dirty,
    output logic                                    touch,
    output dcache_pkg::way_t                        touch_way,
    output logic                                    set_dirty,
    output logic                                    fill,
    output dcache_pkg::way_t                        fill_way,
    output logic                                    beat_clear,
    output logic                                    beat_step,
    input  dcache_pkg::word_sel_t                   beat_count,
    input  logic                                    beat_last,
    output logic [`DCACHE_NUM_WAYS-1:0]             tag_we,
    output dcache_pkg::strb_t [`DCACHE_NUM_WAYS-1:0] data_we,
    output dcache_pkg::index_t                      ram_index,
    output dcache_pkg::word_sel_t                   ram_word,
    output dcache_pkg::word_t                       data_wdata,
    output dcache_pkg::tag_t                        req_tag,
    output logic                                    ar_valid,
    input  logic                                    ar_ready,
    output mem_bus_pkg::mem_addr_t                  ar_addr,
    input  logic                                    r_valid,
    output logic                                    r_ready,
    input  mem_bus_pkg::mem_rbeat_t                 r,
    output logic                                    aw_valid,
    input  logic                                    aw_ready,
    output mem_bus_pkg::mem_addr_t                  aw_addr,
    output logic                                    w_valid,
    input  logic                                    w_ready,
    output mem_bus_pkg::mem_wbeat_t                 w,
    input  logic                                    b_valid,
    output logic                                    b_ready
);

    import dcache_pkg::*;

    fsm_state_t state;
    cpu_req_t   req_q;
    way_t       vway_q;       // way being evicted and refilled
    word_t      miss_word_q;
    logic       accept;
    logic       r_beat;
    logic       w_load;
    logic       on_word;

    function automatic word_t merge_word(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        for (int b = 0; b < $bits(strb_t); b++) begin
            res[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    // only a load hit lets the next request in during lookup
    assign req_ready  = (state == S_IDLE) || (state == S_LOOKUP && hit && !req_q.write);
    assign accept     = req_valid && req_ready;
    assign req_tag    = addr_tag(req_q.addr);
    assign resp_valid = (state == S_LOOKUP && hit) || (state == S_RESPOND);
    assign resp.rdata = (state == S_RESPOND) ? miss_word_q : rdata_way[hit_way];

    assign ar_valid = (state == S_RF_ADDR);
    assign ar_addr  = {req_q.addr[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS],
                       {`DCACHE_OFFSET_BITS{1'b0}}};
    assign r_ready  = (state == S_RF_DATA);
    assign aw_valid = (state == S_WB_ADDR);
    assign w_valid  = (state == S_WB_DATA);
    assign b_ready  = 1'b1;

    assign r_beat  = r_valid && r_ready;
    assign on_word = (beat_count == addr_word(req_q.addr));
    // next victim word goes into the w register
    assign w_load  = (aw_valid && aw_ready) || (w_valid && w_ready && !w.last);

    always_comb begin
        touch      = 1'b0;
        touch_way  = hit_way;
        set_dirty  = req_q.write;
        fill       = 1'b0;
        fill_way   = vway_q;
        beat_clear = accept;
        beat_step  = 1'b0;
        tag_we     = '0;
        data_we    = '0;
        data_wdata = merge_word(rdata_way[hit_way], req_q.wdata, req_q.strb);
        ram_index  = addr_index(req_q.addr);
        ram_word   = beat_count;
        case (state)
            S_LOOKUP: begin
                if (hit) begin
                    touch    = 1'b1;
                    ram_word = addr_word(req_q.addr);
                    if (req_q.write) begin
                        data_we[hit_way] = req_q.strb;
                    end
                end
            end
            S_WB_ADDR, S_WB_DATA: begin
                beat_step = w_load;
                ram_word  = beat_count + word_sel_t'(w_load);  // read one word ahead
            end
            S_RF_ADDR: begin
                beat_clear = 1'b1;
            end
            S_RF_DATA: begin
                if (r_beat) begin
                    beat_step       = 1'b1;
                    data_we[vway_q] = '1;
                    tag_we[vway_q]  = (beat_count == '0);
                    if (req_q.write && on_word) begin
                        data_wdata = merge_word(r.data, req_q.wdata, req_q.strb);
                    end else begin
                        data_wdata = r.data;
                    end
                    if (r.last) begin
                        fill      = 1'b1;
                        touch     = 1'b1;
                        touch_way = vway_q;
                    end
                end
            end
            default: begin
            end
        endcase
        // new request reads tags and data right away
        if (accept) begin
            ram_index = addr_index(req.addr);
            ram_word  = addr_word(req.addr);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        state <= accept ? S_LOOKUP : S_IDLE;
                    end else if (victim_dirty) begin
                        state <= S_WB_ADDR;
                    end else begin
                        state <= S_RF_ADDR;
                    end
                end
                S_WB_ADDR: begin
                    if (aw_ready) begin
                        state <= S_WB_DATA;
                    end
                end
                S_WB_DATA: begin
                    if (w_ready && w.last) begin
                        state <= S_WB_RESP;
                    end
                end
                S_WB_RESP: begin
                    if (b_valid) begin
                        state <= S_RF_ADDR;
                    end
                end
                S_RF_ADDR: begin
                    if (ar_ready) begin
                        state <= S_RF_DATA;
                    end
                end
                S_RF_DATA: begin
                    if (r_valid && r.last) begin
                        state <= S_RESPOND;
                    end
                end
                default: state <= S_IDLE;  // S_RESPOND
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (state == S_LOOKUP && !hit) begin
            vway_q  <= victim_way;
            aw_addr <= {tag_way[victim_way], addr_index(req_q.addr),
                        {`DCACHE_OFFSET_BITS{1'b0}}};
        end
        if (w_load) begin
            w.data <= rdata_way[vway_q];
            w.last <= beat_last;
        end
        if (r_beat && on_word) begin
            miss_word_q <= r.data;
        end
    end

endmodule

// ==== source/dcache_top.sv ====
`include "dcache_config.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  dcache_pkg::cpu_req_t    req,
    output logic                    resp_valid,
    output dcache_pkg::cpu_resp_t   resp,
    output logic                    ar_valid,
    input  logic                    ar_ready,
    output mem_bus_pkg::mem_addr_t  ar_addr,
    input  logic                    r_valid,
    output logic                    r_ready,
    input  mem_bus_pkg::mem_rbeat_t r,
    output logic                    aw_valid,
    input  logic                    aw_ready,
    output mem_bus_pkg::mem_addr_t  aw_addr,
    output logic                    w_valid,
    input  logic                    w_ready,
    output mem_bus_pkg::mem_wbeat_t w,
    input  logic                    b_valid,
    output logic                    b_ready
);

    import dcache_pkg::*;

    word_t [`DCACHE_NUM_WAYS-1:0] rdata_way;
    tag_t [`DCACHE_NUM_WAYS-1:0]  tag_way;
    logic                         hit;
    way_t                         hit_way;
    way_t                         victim_way;
    logic                         victim_dirty;
    logic                         touch;
    way_t                         touch_way;
    logic                         set_dirty;
    logic                         fill;
    way_t                         fill_way;
    logic                         beat_clear;
    logic                         beat_step;
    word_sel_t                    beat_count;
    logic                         beat_last;
    logic [`DCACHE_NUM_WAYS-1:0]  tag_we;
    strb_t [`DCACHE_NUM_WAYS-1:0] data_we;
    index_t                       ram_index;
    word_sel_t                    ram_word;
    word_t                        data_wdata;
    tag_t                         req_tag;

    dcache_fsm u_fsm (.*);

    beat_counter u_beats (
        .clk   (clk),
        .rst   (rst),
        .clear (beat_clear),
        .step  (beat_step),
        .count (beat_count),
        .last  (beat_last)
    );

    dcache_meta u_meta (
        .clk          (clk),
        .rst          (rst),
        .index        (ram_index),
        .lookup_tag   (req_tag),
        .way_tags     (tag_way),
        .touch        (touch),
        .touch_way    (touch_way),
        .set_dirty    (set_dirty),
        .fill         (fill),
        .fill_way     (fill_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

    for (genvar g = 0; g < `DCACHE_NUM_WAYS; g++) begin : g_way
        sync_ram #(
            .data_t (tag_t),
            .DEPTH  (`DCACHE_NUM_SETS)
        ) u_tag_ram (
            .clk   (clk),
            .we    (tag_we[g]),
            .waddr (ram_index),
            .wdata (req_tag),
            .raddr (ram_index),
            .rdata (tag_way[g])
        );

        // merged word comes from the FSM, any strobe bit writes it
        sync_ram #(
            .data_t (word_t),
            .DEPTH  (`DCACHE_NUM_SETS * `DCACHE_WORDS_PER_LINE)
        ) u_data_ram (
            .clk   (clk),
            .we    (|data_we[g]),
            .waddr ({ram_index, ram_word}),
            .wdata (data_wdata),
            .raddr ({ram_index, ram_word}),
            .rdata (rdata_way[g])
        );
    end

endmodule

// ==== tb/mem_model.sv ====
`include "dcache_config.svh"

module mem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  mem_bus_pkg::mem_addr_t  ar_addr,
    output logic                    r_valid,
    input  logic                    r_ready,
    output mem_bus_pkg::mem_rbeat_t r,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  mem_bus_pkg::mem_addr_t  aw_addr,
    input  logic                    w_valid,
    output logic                    w_ready,
    input  mem_bus_pkg::mem_wbeat_t w,
    output logic                    b_valid,
    input  logic                    b_ready,
    output int                      wb_count
);

    timeunit 1ns;
    timeprecision 100ps;

    import mem_bus_pkg::*;

    localparam int WORD_BYTES = `DCACHE_WORD_BITS / 8;

    logic [`DCACHE_WORD_BITS-1:0] mem [mem_addr_t];  // only written words live here
    int        phase = 0;
    mem_addr_t rbase;
    mem_addr_t wbase;
    int        rbeat;
    int        wbeat;

    function automatic logic [`DCACHE_WORD_BITS-1:0] read_word(mem_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a + 32'h1000_0000;  // untouched memory
    endfunction

    // three cycles ready, three cycles not
    assign ar_ready = (phase < 3);
    assign aw_ready = (phase < 3) && !b_valid;  // no new burst while a response waits
    assign w_ready  = (phase < 3);

    initial begin
        r_valid  = 1'b0;
        r        = '0;
        b_valid  = 1'b0;
        wb_count = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            phase    <= 0;
            r_valid  <= 1'b0;
            b_valid  <= 1'b0;
            rbeat    <= 0;
            wbeat    <= 0;
            wb_count <= 0;
        end else begin
            phase <= (phase == 5) ? 0 : phase + 1;
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                rbase   <= ar_addr;
                r_valid <= 1'b1;
                r.data  <= read_word(ar_addr);
                r.last  <= 1'b0;
                rbeat   <= 1;
            end else if (r_valid && r_ready) begin
                if (r.last) begin
                    r_valid <= 1'b0;
                end else begin
                    r.data <= read_word(rbase + WORD_BYTES * rbeat);
                    r.last <= (rbeat == `DCACHE_WORDS_PER_LINE - 1);
                    rbeat  <= rbeat + 1;
                end
            end
            if (aw_valid && aw_ready) begin
                wbase    <= aw_addr;
                wbeat    <= 0;
                wb_count <= wb_count + 1;
            end
            if (w_valid && w_ready) begin
                mem[wbase + WORD_BYTES * wbeat] = w.data;
                wbeat <= wbeat + 1;
                if (w.last) begin
                    b_valid <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== tb/dcache_tb.sv ====
`include "dcache_config.svh"

module dcache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;
    import mem_bus_pkg::*;

    localparam int NUM_RANDOM = 40;
    localparam int RESP_WAIT  = 64;
    localparam int TAG_LSB    = `DCACHE_OFFSET_BITS + `DCACHE_INDEX_BITS;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t strb;
        word_t exp_rdata;
        logic  exp_hit;
        int    exp_wb;  // write bursts started by this access
    } test_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       req_valid;
    logic       req_ready;
    cpu_req_t   req;
    logic       resp_valid;
    cpu_resp_t  resp;
    logic       ar_valid;
    logic       ar_ready;
    mem_addr_t  ar_addr;
    logic       r_valid;
    logic       r_ready;
    mem_rbeat_t r;
    logic       aw_valid;
    logic       aw_ready;
    mem_addr_t  aw_addr;
    logic       w_valid;
    logic       w_ready;
    mem_wbeat_t w;
    logic       b_valid;
    logic       b_ready;
    int         wb_count;

    test_t tests[$];
    word_t shadow_mem [addr_t];
    tag_t  sh_tag   [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
    logic  sh_valid [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
    logic  sh_dirty [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
    logic  sh_lru   [`DCACHE_NUM_SETS];  // way to evict next
    int    sh_wb_total;
    int    errors;
    int    checks;
    int    cycles = 0;
    int    cycle_limit;

    always #2 clk = ~clk;

    dcache_top dut0 (.*);

    mem_model u_mem (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, the run went past %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic word_t apply_strobe(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t expected_word(addr_t a);
        addr_t wa;
        wa = {a[`DCACHE_ADDR_BITS-1:2], 2'b00};
        if (shadow_mem.exists(wa)) begin
            return shadow_mem[wa];
        end
        return wa + 32'h1000_0000;
    endfunction

    // two-way LRU with write-back of dirty victims
    function automatic void model_access(test_t t, output logic hit, output int wb);
        logic [`DCACHE_INDEX_BITS-1:0] idx;
        tag_t                          tag;
        int                            way;
        idx = t.addr[TAG_LSB-1:`DCACHE_OFFSET_BITS];
        tag = t.addr[`DCACHE_ADDR_BITS-1:TAG_LSB];
        hit = 1'b0;
        wb  = 0;
        way = sh_lru[idx];
        for (int k = 0; k < `DCACHE_NUM_WAYS; k++) begin
            if (sh_valid[idx][k] && sh_tag[idx][k] == tag) begin
                hit = 1'b1;
                way = k;
            end
        end
        if (!hit) begin
            wb                 = (sh_valid[idx][way] && sh_dirty[idx][way]) ? 1 : 0;
            sh_valid[idx][way] = 1'b1;
            sh_tag[idx][way]   = tag;
            sh_dirty[idx][way] = 1'b0;
        end
        sh_lru[idx] = (way == 0);
        if (t.write) begin
            sh_dirty[idx][way] = 1'b1;
            shadow_mem[{t.addr[`DCACHE_ADDR_BITS-1:2], 2'b00}] =
                apply_strobe(expected_word(t.addr), t.wdata, t.strb);
        end
    endfunction

    function automatic test_t make_entry(logic write, addr_t addr, word_t wdata, strb_t strb,
                                         word_t exp_rdata, logic exp_hit, int exp_wb);
        test_t t;
        t.write     = write;
        t.addr      = addr;
        t.wdata     = wdata;
        t.strb      = strb;
        t.exp_rdata = exp_rdata;
        t.exp_hit   = exp_hit;
        t.exp_wb    = exp_wb;
        return t;
    endfunction

    task automatic run_entry(int i);
        test_t    t;
        cpu_req_t cr;
        int       wb_before;
        int       err_before;
        int       lat;
        logic     got;
        word_t    rdata;
        t          = tests[i];
        err_before = errors;
        wb_before  = wb_count;
        cr.write   = t.write;
        cr.addr    = t.addr;
        cr.wdata   = t.wdata;
        cr.strb    = t.strb;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= cr;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);  // accept edge
        req_valid <= 1'b0;
        lat   = 0;
        got   = 1'b0;
        rdata = '0;
        while (!got && lat < RESP_WAIT) begin
            @(negedge clk);
            lat++;
            if (resp_valid) begin
                got   = 1'b1;
                rdata = resp.rdata;
            end
        end
        if (!got) begin
            $display("test %0d got no response within %0d cycles of acceptance", i, RESP_WAIT);
            errors++;
        end else begin
            if (!t.write) begin
                check_word("resp.rdata", rdata, t.exp_rdata);
            end
            if (t.exp_hit) begin
                check_count("hit latency", lat, 1);
            end
            check_count("write bursts", wb_count - wb_before, t.exp_wb);
        end
        $display("test %0d %s %h %s", i, t.write ? "store" : "load ", t.addr,
                 (errors == err_before) ? "ok" : "FAIL");
    endtask

    initial begin
        test_t t;
        logic  hit;
        int    wb;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        errors      = 0;
        checks      = 0;
        sh_wb_total = 0;
        void'($urandom(52));
        foreach (sh_valid[s, k]) begin
            sh_valid[s][k] = 1'b0;
            sh_dirty[s][k] = 1'b0;
            sh_tag[s][k]   = '0;
        end
        foreach (sh_lru[s]) begin
            sh_lru[s] = 1'b0;
        end

        // cold load, repeat hit, store hit, store miss
        tests.push_back(make_entry(0, 32'h104, 0, 4'h0, 32'h1000_0104, 0, 0));
        tests.push_back(make_entry(0, 32'h104, 0, 4'h0, 32'h1000_0104, 1, 0));
        tests.push_back(make_entry(1, 32'h108, 32'hAABB_CCDD, 4'b0011, 0, 1, 0));
        tests.push_back(make_entry(0, 32'h108, 0, 4'h0, 32'h1000_CCDD, 1, 0));
        tests.push_back(make_entry(1, 32'h214, 32'h1122_3344, 4'b1100, 0, 0, 0));
        tests.push_back(make_entry(0, 32'h214, 0, 4'h0, 32'h1122_0214, 1, 0));
        // three tags in set 2 with the first one dirty
        tests.push_back(make_entry(1, 32'h020, 32'hDEAD_BEEF, 4'b1111, 0, 0, 0));
        tests.push_back(make_entry(0, 32'h0A0, 0, 4'h0, 32'h1000_00A0, 0, 0));
        tests.push_back(make_entry(0, 32'h120, 0, 4'h0, 32'h1000_0120, 0, 1));
        tests.push_back(make_entry(0, 32'h020, 0, 4'h0, 32'hDEAD_BEEF, 0, 0));
        // clean evictions
        tests.push_back(make_entry(0, 32'h0A0, 0, 4'h0, 32'h1000_00A0, 0, 0));
        tests.push_back(make_entry(0, 32'h120, 0, 4'h0, 32'h1000_0120, 0, 0));
        tests.push_back(make_entry(1, 32'h03C, 32'h5566_7788, 4'b0100, 0, 0, 0));
        tests.push_back(make_entry(0, 32'h03C, 0, 4'h0, 32'h1066_003C, 1, 0));

        foreach (tests[i]) begin
            model_access(tests[i], hit, wb);
            sh_wb_total += wb;
        end
        repeat (NUM_RANDOM) begin
            t.write     = $urandom % 2;
            t.addr      = ($urandom % 32'h200) & ~32'h3;  // tags 0 to 3 in every set
            t.wdata     = $urandom;
            t.strb      = strb_t'($urandom % 15 + 1);
            t.exp_rdata = expected_word(t.addr);
            model_access(t, hit, wb);
            t.exp_hit   = hit;
            t.exp_wb    = wb;
            sh_wb_total += wb;
            tests.push_back(t);
        end
        cycle_limit = tests.size() * RESP_WAIT + 20;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        foreach (tests[i]) begin
            run_entry(i);
        end
        check_count("total write bursts", wb_count, sh_wb_total);
        $display("%0d tests, %0d checks, %0d errors", tests.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+source
source/dcache_pkg.sv
source/mem_bus_pkg.sv
source/sync_ram.sv
source/beat_counter.sv
source/dcache_meta.sv
source/dcache_fsm.sv
source/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - source
    files:
      - source/dcache_pkg.sv
      - source/mem_bus_pkg.sv
      - source/sync_ram.sv
      - source/beat_counter.sv
      - source/dcache_meta.sv
      - source/dcache_fsm.sv
      - source/dcache_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/mem_model.sv
      - tb/dcache_tb.sv
